// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = execute_cluster_tb
FILELIST = list.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx "=== PASS ===" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// File: hdl/cdb_arbiter.sv
module cdb_arbiter
    import rv32i_types::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        alu_valid,
    input  logic [31:0] alu_value,
    input  phys_tag_t   alu_tag,
    input  logic        mul_valid,
    input  logic [31:0] mul_value,
    input  phys_tag_t   mul_tag,
    output logic        alu_grant,
    output logic        cdb_valid,
    output phys_tag_t   cdb_tag,
    output logic [31:0] cdb_value
);

    // Multiplier owns the next CDB slot whenever it finishes
    assign alu_grant = !mul_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= mul_valid || (alu_valid && alu_grant);
        end
    end

    always_ff @(posedge clk) begin
        if (mul_valid) begin
            cdb_tag   <= mul_tag;
            cdb_value <= mul_value;
        end else if (alu_valid) begin
            cdb_tag   <= alu_tag;
            cdb_value <= alu_value;
        end
    end

    // Station never issues an ALU op into a slot the multiplier holds
    alu_only_granted: assert property (@(posedge clk) disable iff (rst)
        alu_valid |-> alu_grant);

endmodule : cdb_arbiter

// File: hdl/execute_cluster.sv
module execute_cluster
    import rv32i_types::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         dispatch_req,
    output logic         dispatch_ack,
    input  decode_info_t dispatch_info,
    input  phys_tag_t    pd,
    input  phys_tag_t    ps1,
    input  logic         ps1_ready,
    input  logic [31:0]  rs1_v,
    input  phys_tag_t    ps2,
    input  logic         ps2_ready,
    input  logic [31:0]  rs2_v,
    output logic         cdb_valid,
    output phys_tag_t    cdb_tag,
    output logic [31:0]  cdb_value
);

    logic         alu_grant;
    logic         alu_start;
    logic         mul_start;
    decode_info_t issue_info;
    logic [31:0]  issue_rs1;
    logic [31:0]  issue_rs2;
    phys_tag_t    issue_tag;

    logic [31:0]  alu_value;
    logic         alu_valid;
    logic [31:0]  mul_product;
    phys_tag_t    mul_tag;
    logic         mul_valid;
    logic         mul_busy;

    reservation_station rs (
        .clk           (clk),
        .rst           (rst),
        .dispatch_req  (dispatch_req),
        .dispatch_ack  (dispatch_ack),
        .dispatch_info (dispatch_info),
        .pd            (pd),
        .ps1           (ps1),
        .ps1_ready     (ps1_ready),
        .rs1_v         (rs1_v),
        .ps2           (ps2),
        .ps2_ready     (ps2_ready),
        .rs2_v         (rs2_v),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_value     (cdb_value),
        .alu_grant     (alu_grant),
        .mul_busy      (mul_busy),
        .alu_start     (alu_start),
        .mul_start     (mul_start),
        .issue_info    (issue_info),
        .issue_rs1     (issue_rs1),
        .issue_rs2     (issue_rs2),
        .issue_tag     (issue_tag)
    );

    fu_add alu (
        .rs1_v       (issue_rs1),
        .rs2_v       (issue_rs2),
        .decode_info (issue_info),
        .rd_v        (alu_value),
        .start       (alu_start),
        .valid       (alu_valid),
        .busy        ()
    );

    fu_mul mul (
        .clk     (clk),
        .rst     (rst),
        .start   (mul_start),
        .a       (issue_rs1),
        .b       (issue_rs2),
        .tag_in  (issue_tag),
        .product (mul_product),
        .tag_out (mul_tag),
        .valid   (mul_valid),
        .busy    (mul_busy)
    );

    cdb_arbiter arb (
        .clk       (clk),
        .rst       (rst),
        .alu_valid (alu_valid),
        .alu_value (alu_value),
        .alu_tag   (issue_tag),
        .mul_valid (mul_valid),
        .mul_value (mul_product),
        .mul_tag   (mul_tag),
        .alu_grant (alu_grant),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_value (cdb_value)
    );

endmodule : execute_cluster

// File: hdl/fu_add.sv
module fu_add
    import rv32i_types::*;
(
    input  logic [31:0]  rs1_v,
    input  logic [31:0]  rs2_v,
    input  decode_info_t decode_info,
    output logic [31:0]  rd_v,
    input  logic         start,
    output logic         valid,
    output logic         busy
);

    logic        [31:0] a;
    logic        [31:0] b;
    logic signed [31:0] as;
    logic signed [31:0] bs;

    alu_ops      aluop;
    branch_f3_t  cmpop;
    logic        use_cmp;

    logic [31:0] aluout;
    logic        br_en;

    // Immediate forms take the sign-extended I-immediate as second operand
    assign a  = rs1_v;
    assign b  = (decode_info.opcode == op_b_imm) ? decode_info.i_imm : rs2_v;
    assign as = signed'(a);
    assign bs = signed'(b);

    // ****************************
    // Operation decode
    // ****************************
    always_comb begin
        aluop   = alu_ops'(decode_info.funct3);
        cmpop   = branch_f3_blt;
        use_cmp = 1'b0;
        case (decode_info.funct3)
            arith_f3_slt: begin
                use_cmp = 1'b1;
            end
            arith_f3_sltu: begin
                use_cmp = 1'b1;
                cmpop   = branch_f3_bltu;
            end
            arith_f3_sr: begin
                // funct7 bit 5 picks the arithmetic shift
                aluop = decode_info.funct7[5] ? alu_op_sra : alu_op_srl;
            end
            arith_f3_add: begin
                if (decode_info.opcode == op_b_reg && decode_info.funct7[5]) begin
                    aluop = alu_op_sub;
                end
            end
            default: begin
                aluop = alu_ops'(decode_info.funct3);
            end
        endcase
    end

    always_comb begin
        case (aluop)
            alu_op_add: aluout = a + b;
            alu_op_sll: aluout = a << b[4:0];
            alu_op_sra: aluout = unsigned'(as >>> b[4:0]);
            alu_op_sub: aluout = a - b;
            alu_op_xor: aluout = a ^ b;
            alu_op_srl: aluout = a >> b[4:0];
            alu_op_or:  aluout = a | b;
            alu_op_and: aluout = a & b;
            default:    aluout = '0;
        endcase
    end

    always_comb begin
        case (cmpop)
            branch_f3_blt:  br_en = (as < bs);
            branch_f3_bltu: br_en = (a < b);
            default:        br_en = 1'b0;
        endcase
    end

    // ****************************
    // Result select
    // ****************************
    always_comb begin
        rd_v = '0;
        if (start) begin
            case (decode_info.opcode)
                op_b_lui: rd_v = decode_info.u_imm;
                op_b_imm,
                op_b_reg: rd_v = use_cmp ? {31'd0, br_en} : aluout;
                default:  rd_v = '0;
            endcase
        end
    end

    // Single cycle unit
    assign valid = start;
    assign busy  = start;

endmodule : fu_add

// File: hdl/fu_mul.sv
module fu_mul
    import rv32i_types::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  phys_tag_t   tag_in,
    output logic [31:0] product,
    output phys_tag_t   tag_out,
    output logic        valid,
    output logic        busy
);

    logic [31:0]               mcand;
    logic [31:0]               mplier;
    logic [31:0]               acc;
    phys_tag_t                 tag_q;
    logic [MUL_COUNT_BITS-1:0] count;
    logic                      running;
    logic                      done;

    // ****************************
    // Iteration control
    // ****************************
    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            done    <= 1'b0;
            count   <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                // Iteration 0 happens on the load
                running <= 1'b1;
                count   <= MUL_COUNT_BITS'(1);
            end else if (running) begin
                count <= count + 1'b1;
                if (count == MUL_COUNT_BITS'(MUL_CYCLES - 1)) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    // Shift-add datapath
    always_ff @(posedge clk) begin
        if (start) begin
            acc    <= b[0] ? a : '0;
            mcand  <= a << 1;
            mplier <= b >> 1;
            tag_q  <= tag_in;
        end else if (running) begin
            acc    <= acc + (mplier[0] ? mcand : 32'd0);
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign product = acc;
    assign tag_out = tag_q;
    assign valid   = done;
    assign busy    = running;

    // Station must hold a MUL back until the loop is idle
    start_when_idle: assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule : fu_mul

// File: hdl/reservation_station.sv
module reservation_station
    import rv32i_types::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         dispatch_req,
    output logic         dispatch_ack,
    input  decode_info_t dispatch_info,
    input  phys_tag_t    pd,
    input  phys_tag_t    ps1,
    input  logic         ps1_ready,
    input  logic [31:0]  rs1_v,
    input  phys_tag_t    ps2,
    input  logic         ps2_ready,
    input  logic [31:0]  rs2_v,
    input  logic         cdb_valid,
    input  phys_tag_t    cdb_tag,
    input  logic [31:0]  cdb_value,
    input  logic         alu_grant,
    input  logic         mul_busy,
    output logic         alu_start,
    output logic         mul_start,
    output decode_info_t issue_info,
    output logic [31:0]  issue_rs1,
    output logic [31:0]  issue_rs2,
    output phys_tag_t    issue_tag
);

    logic [RS_DEPTH-1:0] ent_valid;
    // Bit j of older[i] set means entry j is older than entry i
    logic [RS_DEPTH-1:0] older [RS_DEPTH];
    decode_info_t        ent_info [RS_DEPTH];
    phys_tag_t           ent_pd [RS_DEPTH];
    phys_tag_t           ent_ps1 [RS_DEPTH];
    phys_tag_t           ent_ps2 [RS_DEPTH];
    logic [RS_DEPTH-1:0] ent_r1;
    logic [RS_DEPTH-1:0] ent_r2;
    logic [31:0]         ent_v1 [RS_DEPTH];
    logic [31:0]         ent_v2 [RS_DEPTH];

    logic [RS_DEPTH-1:0]    is_mul;
    logic [RS_DEPTH-1:0]    cand;
    logic [RS_IDX_BITS-1:0] wr_idx;
    logic                   wr_free;
    logic                   wr_en;
    logic [RS_IDX_BITS-1:0] sel_idx;
    logic                   sel_found;
    logic                   cdb_hit1;
    logic                   cdb_hit2;

    // ****************************
    // Issue selection
    // ****************************
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            is_mul[i] = (ent_info[i].opcode == op_b_reg) && (ent_info[i].funct7 == FUNCT7_MULDIV);
            cand[i]   = ent_valid[i] && ent_r1[i] && ent_r2[i] &&
                        (is_mul[i] ? !mul_busy : alu_grant);
        end
    end

    // Oldest candidate has no older candidate
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (cand[i] && !(|(cand & older[i]))) begin
                sel_found = 1'b1;
                sel_idx   = RS_IDX_BITS'(i);
            end
        end
    end

    assign alu_start  = sel_found && !is_mul[sel_idx];
    assign mul_start  = sel_found && is_mul[sel_idx];
    assign issue_info = ent_info[sel_idx];
    assign issue_rs1  = ent_v1[sel_idx];
    assign issue_rs2  = ent_v2[sel_idx];
    assign issue_tag  = ent_pd[sel_idx];

    // ****************************
    // Dispatch
    // ****************************
    always_comb begin
        wr_free = 1'b0;
        wr_idx  = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                wr_free = 1'b1;
                wr_idx  = RS_IDX_BITS'(i);
            end
        end
    end

    assign wr_en    = dispatch_req && !dispatch_ack && wr_free;
    assign cdb_hit1 = cdb_valid && (cdb_tag == ps1);
    assign cdb_hit2 = cdb_valid && (cdb_tag == ps2);

    always_ff @(posedge clk) begin
        if (rst) begin
            dispatch_ack <= 1'b0;
            ent_valid    <= '0;
            for (int i = 0; i < RS_DEPTH; i++) begin
                older[i] <= '0;
            end
        end else begin
            if (wr_en) begin
                dispatch_ack <= 1'b1;
            end else if (!dispatch_req) begin
                dispatch_ack <= 1'b0;
            end
            if (sel_found) begin
                ent_valid[sel_idx] <= 1'b0;
            end
            if (wr_en) begin
                // New entry is younger than everything in flight
                ent_valid[wr_idx] <= 1'b1;
                for (int i = 0; i < RS_DEPTH; i++) begin
                    older[i][wr_idx] <= 1'b0;
                end
                older[wr_idx] <= ent_valid;
            end
        end
    end

    // Operand wakeup from the CDB, then the dispatch write
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (cdb_valid && !ent_r1[i] && cdb_tag == ent_ps1[i]) begin
                ent_r1[i] <= 1'b1;
                ent_v1[i] <= cdb_value;
            end
            if (cdb_valid && !ent_r2[i] && cdb_tag == ent_ps2[i]) begin
                ent_r2[i] <= 1'b1;
                ent_v2[i] <= cdb_value;
            end
        end
        if (wr_en) begin
            ent_info[wr_idx] <= dispatch_info;
            ent_pd[wr_idx]   <= pd;
            ent_ps1[wr_idx]  <= ps1;
            ent_ps2[wr_idx]  <= ps2;
            ent_r1[wr_idx]   <= ps1_ready || cdb_hit1;
            ent_r2[wr_idx]   <= ps2_ready || cdb_hit2;
            ent_v1[wr_idx]   <= (ps1_ready || !cdb_hit1) ? rs1_v : cdb_value;
            ent_v2[wr_idx]   <= (ps2_ready || !cdb_hit2) ? rs2_v : cdb_value;
        end
    end

    // Acked request must own a live entry holding its destination tag
    ack_after_write: assert property (@(posedge clk) disable iff (rst)
        $rose(dispatch_ack) |->
            ent_valid[$past(wr_idx)] && (ent_pd[$past(wr_idx)] == $past(pd)));
    one_issue: assert property (@(posedge clk) disable iff (rst)
        !(alu_start && mul_start));

endmodule : reservation_station

// File: hdl/rv32i_types.sv
package rv32i_types;

    // ****************************
    // Cluster sizes
    // ****************************
    localparam int PHYS_REG_BITS  = 6;
    localparam int RS_DEPTH       = 4;
    localparam int MUL_CYCLES     = 32;
    localparam int RS_IDX_BITS    = $clog2(RS_DEPTH);
    localparam int MUL_COUNT_BITS = $clog2(MUL_CYCLES);

    // funct7 of the M extension
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    typedef logic [PHYS_REG_BITS-1:0] phys_tag_t;

    // ****************************
    // Encodings
    // ****************************
    typedef enum logic [6:0] {
        op_b_imm = 7'b0010011,
        op_b_reg = 7'b0110011,
        op_b_lui = 7'b0110111
    } rv32i_opcode_t;

    typedef enum logic [2:0] {
        arith_f3_add  = 3'b000,
        arith_f3_sll  = 3'b001,
        arith_f3_slt  = 3'b010,
        arith_f3_sltu = 3'b011,
        arith_f3_xor  = 3'b100,
        arith_f3_sr   = 3'b101,
        arith_f3_or   = 3'b110,
        arith_f3_and  = 3'b111
    } arith_f3_t;

    // Shares codes with funct3 for add, sll, xor, srl, or, and
    typedef enum logic [2:0] {
        alu_op_add = 3'b000,
        alu_op_sll = 3'b001,
        alu_op_sra = 3'b010,
        alu_op_sub = 3'b011,
        alu_op_xor = 3'b100,
        alu_op_srl = 3'b101,
        alu_op_or  = 3'b110,
        alu_op_and = 3'b111
    } alu_ops;

    typedef enum logic [2:0] {
        branch_f3_beq  = 3'b000,
        branch_f3_bne  = 3'b001,
        branch_f3_blt  = 3'b100,
        branch_f3_bge  = 3'b101,
        branch_f3_bltu = 3'b110,
        branch_f3_bgeu = 3'b111
    } branch_f3_t;

    typedef struct packed {
        rv32i_opcode_t opcode;
        logic [2:0]    funct3;
        logic [6:0]    funct7;
        logic [31:0]   i_imm;
        logic [31:0]   u_imm;
    } decode_info_t;

endpackage : rv32i_types

// File: list.f
hdl/rv32i_types.sv
hdl/fu_add.sv
hdl/fu_mul.sv
hdl/reservation_station.sv
hdl/cdb_arbiter.sv
hdl/execute_cluster.sv
tests/execute_cluster_tb.sv

// File: tests/execute_cluster_tb.sv
module execute_cluster_tb
    import rv32i_types::*;
();

    localparam int MAX_ROWS = 48;
    localparam int NUM_TAGS = 1 << PHYS_REG_BITS;
    // Source column: a positive number is the tag of an earlier row
    localparam int SRC_RAND = 0;
    localparam int SRC_NEG  = -1;
    localparam int SRC_POS  = -2;

    logic         clk;
    logic         rst;
    logic         dispatch_req;
    logic         dispatch_ack;
    decode_info_t dispatch_info;
    phys_tag_t    pd;
    phys_tag_t    ps1;
    logic         ps1_ready;
    logic [31:0]  rs1_v;
    phys_tag_t    ps2;
    logic         ps2_ready;
    logic [31:0]  rs2_v;
    logic         cdb_valid;
    phys_tag_t    cdb_tag;
    logic [31:0]  cdb_value;

    // ****************************
    // Stimulus table
    // ****************************
    string        row_name [MAX_ROWS];
    decode_info_t row_info [MAX_ROWS];
    int           row_src1 [MAX_ROWS];
    int           row_src2 [MAX_ROWS];
    logic [31:0]  row_op1 [MAX_ROWS];
    logic [31:0]  row_op2 [MAX_ROWS];
    logic [31:0]  row_exp [MAX_ROWS];
    int           num_rows;
    logic         table_ready;

    // Scoreboard indexed by tag
    int           sb_count [NUM_TAGS];
    logic [31:0]  sb_value [NUM_TAGS];
    int           disp_cycle [NUM_TAGS];

    int           done_count;
    int           value_errors;
    int           other_errors;
    int           stall_count;
    int           cycle;
    logic [15:0]  lfsr_state;

    execute_cluster uut (
        .clk           (clk),
        .rst           (rst),
        .dispatch_req  (dispatch_req),
        .dispatch_ack  (dispatch_ack),
        .dispatch_info (dispatch_info),
        .pd            (pd),
        .ps1           (ps1),
        .ps1_ready     (ps1_ready),
        .rs1_v         (rs1_v),
        .ps2           (ps2),
        .ps2_ready     (ps2_ready),
        .rs2_v         (rs2_v),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_value     (cdb_value)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Galois LFSR, x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // RV32I result of one operation
    function automatic logic [31:0] rv32i_result(input decode_info_t info,
                                                 input logic [31:0] a,
                                                 input logic [31:0] b);
        logic [31:0] op2;
        logic [4:0]  sh;
        logic        alt;
        logic [31:0] res;
        op2 = (info.opcode == op_b_imm) ? info.i_imm : b;
        sh  = op2[4:0];
        alt = info.funct7[5];
        case (info.funct3)
            3'd0:    res = (info.opcode == op_b_reg && alt) ? a - op2 : a + op2;
            3'd1:    res = a << sh;
            3'd2:    res = {31'd0, $signed(a) < $signed(op2)};
            3'd3:    res = {31'd0, a < op2};
            3'd4:    res = a ^ op2;
            3'd5:    res = alt ? 32'($signed(a) >>> sh) : a >> sh;
            3'd6:    res = a | op2;
            default: res = a & op2;
        endcase
        if (info.opcode == op_b_reg && info.funct7 == 7'b0000001) begin
            res = a * b;
        end
        if (info.opcode == op_b_lui) begin
            res = info.u_imm;
        end
        return res;
    endfunction

    function automatic logic [31:0] source_value(input int src);
        logic [31:0] v;
        if (src > 0) begin
            v = row_exp[src - 1];
        end else begin
            v = draw_bits(32);
            if (src == SRC_NEG) begin
                v[31] = 1'b1;
            end else if (src == SRC_POS) begin
                v[31] = 1'b0;
            end
        end
        return v;
    endfunction

    task automatic add_row(input string name, input rv32i_opcode_t opcode,
                           input logic [2:0] f3, input logic [6:0] f7,
                           input int src1, input int src2);
        decode_info_t info;
        logic [31:0]  imm;
        logic [31:0]  upper;
        imm = draw_bits(12);
        // Shift immediates carry funct7 above the shift amount
        if (opcode == op_b_imm && (f3 == 3'd1 || f3 == 3'd5)) begin
            imm = {20'd0, f7, imm[4:0]};
        end
        imm   = {{20{imm[11]}}, imm[11:0]};
        upper = draw_bits(20);
        info.opcode = opcode;
        info.funct3 = f3;
        info.funct7 = (opcode == op_b_imm) ? imm[11:5] : f7;
        info.i_imm  = imm;
        info.u_imm  = {upper[19:0], 12'd0};
        row_name[num_rows] = name;
        row_info[num_rows] = info;
        row_src1[num_rows] = src1;
        row_src2[num_rows] = src2;
        row_op1[num_rows]  = source_value(src1);
        row_op2[num_rows]  = source_value(src2);
        row_exp[num_rows]  = rv32i_result(info, row_op1[num_rows], row_op2[num_rows]);
        num_rows++;
    endtask

    task automatic build_table();
        int t_mul;
        num_rows = 0;
        add_row("add",      op_b_reg, 3'd0, 7'h00, SRC_RAND, SRC_RAND);
        add_row("sub",      op_b_reg, 3'd0, 7'h20, SRC_RAND, SRC_RAND);
        add_row("sll",      op_b_reg, 3'd1, 7'h00, SRC_RAND, SRC_RAND);
        add_row("slt",      op_b_reg, 3'd2, 7'h00, SRC_RAND, SRC_RAND);
        add_row("slt_neg",  op_b_reg, 3'd2, 7'h00, SRC_NEG,  SRC_POS);
        add_row("sltu",     op_b_reg, 3'd3, 7'h00, SRC_RAND, SRC_RAND);
        add_row("sltu_neg", op_b_reg, 3'd3, 7'h00, SRC_NEG,  SRC_POS);
        add_row("xor",      op_b_reg, 3'd4, 7'h00, SRC_RAND, SRC_RAND);
        add_row("srl_neg",  op_b_reg, 3'd5, 7'h00, SRC_NEG,  SRC_RAND);
        add_row("sra_neg",  op_b_reg, 3'd5, 7'h20, SRC_NEG,  SRC_RAND);
        add_row("or",       op_b_reg, 3'd6, 7'h00, SRC_RAND, SRC_RAND);
        add_row("and",      op_b_reg, 3'd7, 7'h00, SRC_RAND, SRC_RAND);
        add_row("addi",     op_b_imm, 3'd0, 7'h00, SRC_RAND, SRC_RAND);
        add_row("slti_neg", op_b_imm, 3'd2, 7'h00, SRC_NEG,  SRC_RAND);
        add_row("sltiu",    op_b_imm, 3'd3, 7'h00, SRC_NEG,  SRC_RAND);
        add_row("xori",     op_b_imm, 3'd4, 7'h00, SRC_RAND, SRC_RAND);
        add_row("ori",      op_b_imm, 3'd6, 7'h00, SRC_RAND, SRC_RAND);
        add_row("andi",     op_b_imm, 3'd7, 7'h00, SRC_RAND, SRC_RAND);
        add_row("slli",     op_b_imm, 3'd1, 7'h00, SRC_RAND, SRC_RAND);
        add_row("srli_neg", op_b_imm, 3'd5, 7'h00, SRC_NEG,  SRC_RAND);
        add_row("srai_neg", op_b_imm, 3'd5, 7'h20, SRC_NEG,  SRC_RAND);
        add_row("lui",      op_b_lui, 3'd0, 7'h00, SRC_RAND, SRC_RAND);
        add_row("mul_lit",  op_b_reg, 3'd0, 7'h01, SRC_RAND, SRC_NEG);
        // Chain behind a MUL, deep enough to fill the station
        t_mul = num_rows + 1;
        add_row("mul_head", op_b_reg, 3'd0, 7'h01, SRC_RAND, SRC_RAND);
        add_row("dep_add",  op_b_reg, 3'd0, 7'h00, t_mul,    SRC_RAND);
        add_row("dep_sub",  op_b_reg, 3'd0, 7'h20, num_rows, SRC_RAND);
        add_row("dep_xor",  op_b_reg, 3'd4, 7'h00, t_mul,    num_rows);
        add_row("dep_srai", op_b_imm, 3'd5, 7'h20, num_rows, SRC_RAND);
        add_row("dep_sltu", op_b_reg, 3'd3, 7'h00, num_rows, t_mul);
        add_row("mul_dep",  op_b_reg, 3'd0, 7'h01, num_rows, t_mul);
        add_row("after_mul", op_b_reg, 3'd6, 7'h00, num_rows, SRC_RAND);
        add_row("old_src",  op_b_reg, 3'd0, 7'h00, 1,        num_rows - 1);
    endtask

    // Ready value comes from the scoreboard or from the CDB of this cycle
    task automatic lookup_source(input int src, input logic [31:0] lit,
                                 output logic ready, output logic [31:0] value);
        if (src <= 0) begin
            ready = 1'b1;
            value = lit;
        end else if (sb_count[src] > 0) begin
            ready = 1'b1;
            value = sb_value[src];
        end else if (cdb_valid && cdb_tag == phys_tag_t'(src)) begin
            ready = 1'b1;
            value = cdb_value;
        end else begin
            ready = 1'b0;
            value = '0;
        end
    endtask

    task automatic resolve_sources(input int r);
        lookup_source(row_src1[r], row_op1[r], ps1_ready, rs1_v);
        lookup_source(row_src2[r], row_op2[r], ps2_ready, rs2_v);
    endtask

    // Called on a falling edge with dispatch_ack low
    task automatic dispatch_row(input int r);
        int waited;
        dispatch_info = row_info[r];
        pd            = phys_tag_t'(r + 1);
        ps1           = phys_tag_t'(row_src1[r] > 0 ? row_src1[r] : 0);
        ps2           = phys_tag_t'(row_src2[r] > 0 ? row_src2[r] : 0);
        resolve_sources(r);
        dispatch_req = 1'b1;
        @(negedge clk);
        waited = 1;
        while (!dispatch_ack) begin
            resolve_sources(r);
            @(negedge clk);
            waited++;
        end
        disp_cycle[r + 1] = cycle;
        dispatch_req      = 1'b0;
        if (waited > 1) begin
            stall_count++;
        end
        while (dispatch_ack) begin
            @(negedge clk);
        end
    endtask

    // ****************************
    // CDB monitor
    // ****************************
    always @(negedge clk) begin
        int r;
        if (!rst && cdb_valid) begin
            r = int'(cdb_tag) - 1;
            if (r < 0 || r >= num_rows) begin
                $display("CDB carried tag %0d, which no row dispatched", cdb_tag);
                other_errors++;
            end else if (sb_count[r + 1] == 0) begin
                assert (cdb_value == row_exp[r]) else begin
                    $display("FAIL %s expected %h actual %h", row_name[r], row_exp[r],
                             cdb_value);
                    value_errors++;
                end
                if (row_info[r].opcode == op_b_reg && row_info[r].funct7 == 7'b0000001) begin
                    assert (cycle - disp_cycle[r + 1] >= MUL_CYCLES) else begin
                        $display("FAIL %s expected latency >= %0d actual %0d", row_name[r],
                                 MUL_CYCLES, cycle - disp_cycle[r + 1]);
                        value_errors++;
                    end
                end
                sb_value[r + 1] = cdb_value;
                done_count++;
            end
            if (r >= 0 && r < num_rows) begin
                sb_count[r + 1]++;
            end
        end
    end

    initial begin
        wait (table_ready);
        repeat (num_rows * (MUL_CYCLES + 10)) @(posedge clk);
        $display("Run stopped by the watchdog at cycle %0d", cycle);
        for (int t = 1; t <= num_rows; t++) begin
            if (sb_count[t] == 0) begin
                $display("Tag %0d of row %s never completed", t, row_name[t - 1]);
            end
        end
        $display("errors: %0d value, %0d other", value_errors, other_errors + 1);
        $display("=== FAIL ===");
        $finish;
    end

    // ****************************
    // Main sequence
    // ****************************
    initial begin
        rst           = 1'b1;
        dispatch_req  = 1'b0;
        dispatch_info = '0;
        pd            = '0;
        ps1           = '0;
        ps1_ready     = 1'b0;
        rs1_v         = '0;
        ps2           = '0;
        ps2_ready     = 1'b0;
        rs2_v         = '0;
        cycle         = 0;
        done_count    = 0;
        value_errors  = 0;
        other_errors  = 0;
        stall_count   = 0;
        table_ready   = 1'b0;
        for (int t = 0; t < NUM_TAGS; t++) begin
            sb_count[t]   = 0;
            sb_value[t]   = '0;
            disp_cycle[t] = 0;
        end
        lfsr_state = 16'd10964;
        build_table();
        table_ready = 1'b1;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (!cdb_valid && !dispatch_ack) else begin
            $display("FAIL reset_idle expected 00 actual %b%b", cdb_valid, dispatch_ack);
            value_errors++;
        end

        for (int r = 0; r < num_rows; r++) begin
            dispatch_row(r);
        end
        wait (done_count == num_rows);
        // Leave room for a stray or repeated broadcast
        repeat (MUL_CYCLES + 4) @(negedge clk);

        for (int t = 1; t <= num_rows; t++) begin
            assert (sb_count[t] == 1) else begin
                $display("Tag %0d of row %s appeared %0d times on the CDB", t,
                         row_name[t - 1], sb_count[t]);
                other_errors++;
            end
        end
        assert (stall_count > 0) else begin
            $display("Dispatch was never held back by a full station");
            other_errors++;
        end

        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule : execute_cluster_tb
